//--- rename_types_pkg.sv
package rename_types_pkg;

    // Register file sizes
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PREGS     = 64;
    // Pregs not holding committed state at reset
    localparam int FREE_DEPTH    = NUM_PREGS - NUM_ARCH_REGS;

    // Slots per rename group, fixed by the two-port free list
    localparam int GROUP_WIDTH   = 2;
    // Map reads per group: src1, src2 and old dest for each slot
    localparam int MAP_READS     = 3 * GROUP_WIDTH;

    typedef logic [4:0] arch_reg_t;
    typedef logic [5:0] preg_t;

    // One slot of an incoming group
    typedef struct packed {
        logic      valid;
        logic      dest_valid;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
    } rename_req_t;

    // One slot after renaming
    typedef struct packed {
        logic  valid;
        preg_t psrc1;
        preg_t psrc2;
        preg_t pdest;
        preg_t old_pdest;
        logic  dest_valid;
    } renamed_uop_t;

    // Record kept per uop until commit or walk
    typedef struct packed {
        logic      dest_valid;
        arch_reg_t dest;
        preg_t     pdest;
        preg_t     old_pdest;
    } rob_entry_t;

    // Dest of an older slot, seen by younger slots for bypass
    typedef struct packed {
        logic      valid;
        arch_reg_t dest;
        preg_t     pdest;
    } older_dest_t;

endpackage

//--- rename_ctrl_pkg.sv
package rename_ctrl_pkg;

    // ROB recovery state
    typedef enum logic {
        WALK_IDLE,
        WALK_ACTIVE
    } walk_state_t;

    // Zero to two uops per cycle
    typedef logic [1:0] commit_cnt_t;

endpackage

//--- freelist.sv
`timescale 1ns/10ps
module freelist
    import rename_types_pkg::*;
    import rename_ctrl_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    // Allocate side, head of the queue
    input  commit_cnt_t alloc_take,
    output preg_t       alloc_preg [GROUP_WIDTH],
    output logic [5:0]  free_count,
    // Release side, from commit
    input  logic [1:0]  release_valid,
    input  preg_t       release_preg [GROUP_WIDTH],
    // Rewind during walk
    input  commit_cnt_t walk_count
);

    localparam int PTR_W = $clog2(FREE_DEPTH);

    typedef logic [PTR_W-1:0] fl_ptr_t;

    preg_t      mem [FREE_DEPTH];
    fl_ptr_t    enq_ptr;
    fl_ptr_t    deq_ptr;
    fl_ptr_t    deq_ptr_p1;
    fl_ptr_t    rel_idx1;
    logic [5:0] count;
    logic [1:0] rel_num;

    // ----------------------------------------
    // Read side
    // ----------------------------------------

    // Pointers wrap at FREE_DEPTH, a power of two
    assign deq_ptr_p1 = deq_ptr + 1'b1;

    // Two oldest free pregs, always presented
    assign alloc_preg[0] = mem[deq_ptr];
    assign alloc_preg[1] = mem[deq_ptr_p1];

    assign free_count = count;

    // Second release lands after the first only if the first is used
    assign rel_num  = {1'b0, release_valid[0]} + {1'b0, release_valid[1]};
    assign rel_idx1 = enq_ptr + fl_ptr_t'(release_valid[0]);

    // ----------------------------------------
    // Queue update
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
            count   <= 6'(FREE_DEPTH);
            // Pregs 32..63 free after reset, in order
            for (int i = 0; i < FREE_DEPTH; i++) begin
                mem[i] <= preg_t'(NUM_ARCH_REGS + i);
            end
        end else begin
            // Old dests back in commit order
            if (release_valid[0]) begin
                mem[enq_ptr] <= release_preg[0];
            end
            if (release_valid[1]) begin
                mem[rel_idx1] <= release_preg[1];
            end
            enq_ptr <= enq_ptr + fl_ptr_t'(rel_num);
            // Walk rewinds over entries that still hold the handed-out pregs
            deq_ptr <= deq_ptr + fl_ptr_t'(alloc_take) - fl_ptr_t'(walk_count);
            count   <= count + 6'(rel_num) + 6'(walk_count) - 6'(alloc_take);
        end
    end

endmodule

//--- rename_map_table.sv
`timescale 1ns/10ps
module rename_map_table
    import rename_types_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    // Combinational reads of the current map
    input  arch_reg_t    rd_arch [MAP_READS],
    output preg_t        rd_preg [MAP_READS],
    // Speculative update from the firing group
    input  renamed_uop_t wr_uop [GROUP_WIDTH],
    input  arch_reg_t    wr_dest [GROUP_WIDTH],
    input  logic         wr_fire,
    // Restore during walk, newest entry in slot 0
    input  rob_entry_t   walk_restore [GROUP_WIDTH],
    input  logic [1:0]   walk_valid
);

    preg_t map_q [NUM_ARCH_REGS];

    // Read ports
    always_comb begin
        for (int k = 0; k < MAP_READS; k++) begin
            rd_preg[k] = map_q[rd_arch[k]];
        end
    end

    // ----------------------------------------
    // Map update
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            // Identity map after reset
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else begin
            // Age order, younger slot last so it wins
            if (wr_fire) begin
                for (int s = 0; s < GROUP_WIDTH; s++) begin
                    if (wr_uop[s].valid && wr_uop[s].dest_valid) begin
                        map_q[wr_dest[s]] <= wr_uop[s].pdest;
                    end
                end
            end
            // Newer entry first, older entry's old_pdest lands last
            for (int w = 0; w < GROUP_WIDTH; w++) begin
                if (walk_valid[w]) begin
                    map_q[walk_restore[w].dest] <= walk_restore[w].old_pdest;
                end
            end
        end
    end

endmodule

//--- rename_lane.sv
`timescale 1ns/10ps
module rename_lane
    import rename_types_pkg::*;
#(
    parameter  int LANE = 0,
    // At least one element so slot 0 still has a legal port
    localparam int NOLD = (LANE > 0) ? LANE : 1
)(
    input  rename_req_t              req,
    // src1, src2, old dest mapping from the map table
    input  preg_t                    map_src [3],
    input  older_dest_t [NOLD-1:0]   older_dests,
    input  preg_t                    new_preg,
    output renamed_uop_t             uop
);

    preg_t psrc1;
    preg_t psrc2;
    preg_t old_pdest;

    // ----------------------------------------
    // In-group bypass
    // ----------------------------------------
    always_comb begin
        psrc1     = map_src[0];
        psrc2     = map_src[1];
        old_pdest = map_src[2];
        // Oldest to youngest, youngest match overrides
        for (int j = 0; j < LANE; j++) begin
            if (older_dests[j].valid) begin
                if (older_dests[j].dest == req.src1) begin
                    psrc1 = older_dests[j].pdest;
                end
                if (older_dests[j].dest == req.src2) begin
                    psrc2 = older_dests[j].pdest;
                end
                if (older_dests[j].dest == req.dest) begin
                    old_pdest = older_dests[j].pdest;
                end
            end
        end
    end

    // Dest fields zero when the slot writes nothing
    always_comb begin
        uop.valid      = req.valid;
        uop.psrc1      = psrc1;
        uop.psrc2      = psrc2;
        uop.pdest      = req.dest_valid ? new_preg : '0;
        uop.old_pdest  = req.dest_valid ? old_pdest : '0;
        uop.dest_valid = req.dest_valid;
    end

endmodule

//--- rename_rob.sv
`timescale 1ns/10ps
module rename_rob
    import rename_types_pkg::*;
    import rename_ctrl_pkg::*;
#(
    parameter int ROB_DEPTH = 16
)(
    input  logic                           clock,
    input  logic                           reset_n,
    // Push from the firing group
    input  renamed_uop_t                   push_uop [GROUP_WIDTH],
    input  arch_reg_t                      push_dest [GROUP_WIDTH],
    input  logic                           push_fire,
    // Commit and recovery
    input  commit_cnt_t                    commit_req,
    input  logic                           flush,
    output logic [$clog2(ROB_DEPTH+1)-1:0] free_slots,
    output logic                           walk_busy,
    // To the free list
    output logic [1:0]                     release_valid,
    output preg_t                          release_preg [GROUP_WIDTH],
    output commit_cnt_t                    walk_count,
    // To the map table, newest first
    output rob_entry_t                     walk_restore [GROUP_WIDTH],
    output logic [1:0]                     walk_valid
);

    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    typedef logic [PTR_W-1:0] rob_ptr_t;
    typedef logic [CNT_W-1:0] rob_cnt_t;

    rob_entry_t  mem [ROB_DEPTH];
    rob_entry_t  push_entry [GROUP_WIDTH];
    rob_ptr_t    head;
    rob_ptr_t    tail;
    rob_ptr_t    head_p1;
    rob_ptr_t    tail_m1;
    rob_ptr_t    tail_m2;
    rob_ptr_t    push_idx1;
    rob_cnt_t    count;
    walk_state_t state;
    commit_cnt_t commit_lim;
    commit_cnt_t commit_n;
    commit_cnt_t walk_n;
    commit_cnt_t push_n;

    assign walk_busy  = (state == WALK_ACTIVE);
    assign free_slots = rob_cnt_t'(ROB_DEPTH) - count;

    assign head_p1   = head + 1'b1;
    assign tail_m1   = tail - 1'b1;
    assign tail_m2   = tail - 2'd2;
    assign push_idx1 = tail + rob_ptr_t'(push_uop[0].valid);

    // ----------------------------------------
    // Per-cycle counts
    // ----------------------------------------
    always_comb begin
        commit_lim = (commit_req > 2'd2) ? 2'd2 : commit_req;
        // Commit held off during walk, capped by occupancy
        if (walk_busy) begin
            commit_n = '0;
        end else if (count < rob_cnt_t'(commit_lim)) begin
            commit_n = commit_cnt_t'(count);
        end else begin
            commit_n = commit_lim;
        end
        // Walk pops up to two from the tail
        if (!walk_busy) begin
            walk_n = '0;
        end else if (count < rob_cnt_t'(2)) begin
            walk_n = commit_cnt_t'(count);
        end else begin
            walk_n = 2'd2;
        end
        push_n = '0;
        if (push_fire) begin
            push_n = commit_cnt_t'(push_uop[0].valid) + commit_cnt_t'(push_uop[1].valid);
        end
    end

    // Commit release, oldest entry in slot 0
    assign release_valid[0] = (commit_n != 2'd0) && mem[head].dest_valid;
    assign release_valid[1] = (commit_n == 2'd2) && mem[head_p1].dest_valid;
    assign release_preg[0]  = mem[head].old_pdest;
    assign release_preg[1]  = mem[head_p1].old_pdest;

    // Walk restore, newest entry in slot 0
    assign walk_restore[0] = mem[tail_m1];
    assign walk_restore[1] = mem[tail_m2];
    assign walk_valid[0]   = (walk_n != 2'd0) && mem[tail_m1].dest_valid;
    assign walk_valid[1]   = (walk_n == 2'd2) && mem[tail_m2].dest_valid;
    // Only dest-writing entries took a preg from the free list
    assign walk_count = commit_cnt_t'(walk_valid[0]) + commit_cnt_t'(walk_valid[1]);

    // ----------------------------------------
    // Entry storage
    // ----------------------------------------
    always_comb begin
        for (int s = 0; s < GROUP_WIDTH; s++) begin
            push_entry[s].dest_valid = push_uop[s].dest_valid;
            push_entry[s].dest       = push_dest[s];
            push_entry[s].pdest      = push_uop[s].pdest;
            push_entry[s].old_pdest  = push_uop[s].old_pdest;
        end
    end

    // Valid slots packed in age order
    always_ff @(posedge clock) begin
        if (push_fire && push_uop[0].valid) begin
            mem[tail] <= push_entry[0];
        end
        if (push_fire && push_uop[1].valid) begin
            mem[push_idx1] <= push_entry[1];
        end
    end

    // ----------------------------------------
    // Pointers and walk FSM
    // ----------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            state <= WALK_IDLE;
        end else begin
            head  <= head + rob_ptr_t'(commit_n);
            tail  <= tail + rob_ptr_t'(push_n) - rob_ptr_t'(walk_n);
            count <= count + rob_cnt_t'(push_n) - rob_cnt_t'(commit_n) - rob_cnt_t'(walk_n);
            case (state)
                // Same-cycle commit first, walk only what remains
                WALK_IDLE: begin
                    if (flush && (count != rob_cnt_t'(commit_n))) begin
                        state <= WALK_ACTIVE;
                    end
                end
                // Done once the last entries pop
                WALK_ACTIVE: begin
                    if (count == rob_cnt_t'(walk_n)) begin
                        state <= WALK_IDLE;
                    end
                end
                default: begin
                    state <= WALK_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rename_top.sv
`timescale 1ns/10ps
module rename_top
    import rename_types_pkg::*;
    import rename_ctrl_pkg::*;
#(
    parameter int ROB_DEPTH = 16
)(
    input  logic         clock,
    input  logic         reset_n,
    // Slot 0 is the oldest
    input  rename_req_t  rename_in [GROUP_WIDTH],
    output logic         rename_ready,
    output renamed_uop_t renamed_out [GROUP_WIDTH],
    input  commit_cnt_t  commit_req,
    input  logic         flush,
    output logic         walk_busy
);

    logic [GROUP_WIDTH-1:0]         need;
    commit_cnt_t                    need_total;
    commit_cnt_t                    alloc_take;
    logic                           fire;
    preg_t                          alloc_preg [GROUP_WIDTH];
    preg_t                          lane_preg [GROUP_WIDTH];
    logic [5:0]                     free_count;
    logic [$clog2(ROB_DEPTH+1)-1:0] free_slots;
    arch_reg_t                      rd_arch [MAP_READS];
    preg_t                          rd_preg [MAP_READS];
    renamed_uop_t                   uops [GROUP_WIDTH];
    arch_reg_t                      slot_dest [GROUP_WIDTH];
    logic [1:0]                     release_valid;
    preg_t                          release_preg [GROUP_WIDTH];
    commit_cnt_t                    walk_count;
    rob_entry_t                     walk_restore [GROUP_WIDTH];
    logic [1:0]                     walk_valid;

    // ----------------------------------------
    // Ready and allocation
    // ----------------------------------------

    // Each slot takes the next preg past the ones older slots took
    always_comb begin
        need_total = '0;
        for (int i = 0; i < GROUP_WIDTH; i++) begin
            need[i]      = rename_in[i].valid && rename_in[i].dest_valid;
            lane_preg[i] = alloc_preg[need_total[0]];
            need_total   = need_total + commit_cnt_t'(need[i]);
        end
    end

    // Stall on walk, flush, ROB space or free pregs
    assign rename_ready = !walk_busy && !flush
                       && (int'(free_slots) >= GROUP_WIDTH)
                       && (free_count >= 6'(need_total));

    assign fire       = rename_ready && (rename_in[0].valid || rename_in[1].valid);
    assign alloc_take = fire ? need_total : '0;

    // ----------------------------------------
    // Rename slots
    // ----------------------------------------
    for (genvar i = 0; i < GROUP_WIDTH; i++) begin : g_lane
        localparam int NOLD = (i > 0) ? i : 1;

        older_dest_t [NOLD-1:0] older;
        preg_t                  map_src [3];

        for (genvar j = 0; j < NOLD; j++) begin : g_older
            if (j < i) begin : g_used
                assign older[j] = '{valid: need[j], dest: rename_in[j].dest,
                                    pdest: lane_preg[j]};
            end else begin : g_none
                assign older[j] = '0;
            end
        end

        // Three map reads per slot
        assign rd_arch[3*i]     = rename_in[i].src1;
        assign rd_arch[3*i + 1] = rename_in[i].src2;
        assign rd_arch[3*i + 2] = rename_in[i].dest;
        assign map_src[0]       = rd_preg[3*i];
        assign map_src[1]       = rd_preg[3*i + 1];
        assign map_src[2]       = rd_preg[3*i + 2];
        assign slot_dest[i]     = rename_in[i].dest;

        rename_lane #(
            .LANE(i)
        ) u_lane (
            .req         (rename_in[i]),
            .map_src     (map_src),
            .older_dests (older),
            .new_preg    (lane_preg[i]),
            .uop         (uops[i])
        );

        // Output valid only in the cycle the group is taken
        always_comb begin
            renamed_out[i]       = uops[i];
            renamed_out[i].valid = uops[i].valid && rename_ready;
        end
    end

    // ----------------------------------------
    // Shared state
    // ----------------------------------------
    freelist u_freelist (
        .clock         (clock),
        .reset_n       (reset_n),
        .alloc_take    (alloc_take),
        .alloc_preg    (alloc_preg),
        .free_count    (free_count),
        .release_valid (release_valid),
        .release_preg  (release_preg),
        .walk_count    (walk_count)
    );

    rename_map_table u_map (
        .clock        (clock),
        .reset_n      (reset_n),
        .rd_arch      (rd_arch),
        .rd_preg      (rd_preg),
        .wr_uop       (uops),
        .wr_dest      (slot_dest),
        .wr_fire      (fire),
        .walk_restore (walk_restore),
        .walk_valid   (walk_valid)
    );

    rename_rob #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_rob (
        .clock         (clock),
        .reset_n       (reset_n),
        .push_uop      (uops),
        .push_dest     (slot_dest),
        .push_fire     (fire),
        .commit_req    (commit_req),
        .flush         (flush),
        .free_slots    (free_slots),
        .walk_busy     (walk_busy),
        .release_valid (release_valid),
        .release_preg  (release_preg),
        .walk_count    (walk_count),
        .walk_restore  (walk_restore),
        .walk_valid    (walk_valid)
    );

endmodule

//--- rename_props.sv
`timescale 1ns/10ps
module rename_props
    import rename_types_pkg::*;
(
    input logic       clock,
    input logic       reset_n,
    input logic       rename_ready,
    input logic       walk_busy,
    input logic [5:0] free_count
);

    // ----------------------------------------
    // Rename stage invariants
    // ----------------------------------------

    // Walk only hands pregs back, nothing allocated meanwhile
    a_walk_no_alloc: assert property (
        @(posedge clock) disable iff (!reset_n)
        walk_busy |=> (free_count >= $past(free_count))
    ) else $error("free list shrank during walk");

    // Queue holds at most the non-architectural pregs
    a_free_count_bound: assert property (
        @(posedge clock) disable iff (!reset_n)
        free_count <= 6'(FREE_DEPTH)
    ) else $error("free list count above its depth");

    // Empty ROB and full free list right out of reset
    a_ready_after_reset: assert property (
        @(posedge clock)
        $rose(reset_n) |-> rename_ready
    ) else $error("rename_ready low after reset");

endmodule

bind rename_top rename_props u_props (
    .clock        (clock),
    .reset_n      (reset_n),
    .rename_ready (rename_ready),
    .walk_busy    (walk_busy),
    .free_count   (free_count)
);

//--- rename_tb.sv
`timescale 1ns/10ps
module rename_tb
    import rename_types_pkg::*;
    import rename_ctrl_pkg::*;
;

    localparam int ROB_DEPTH = 16;

    // Planned cycles per test, used for the run limit
    localparam int T_RESET = 8;
    localparam int T1      = 4;
    localparam int T2      = 40;
    localparam int T3      = 30;
    localparam int T4      = 60;
    localparam int T5      = 3 * (6 + 1 + (ROB_DEPTH / 2 + 2) + 10);
    localparam int T6      = 400;
    localparam int LIMIT   = T_RESET + T1 + T2 + T3 + T4 + T5 + T6 + 100;

    logic         clock;
    logic         reset_n;
    rename_req_t  rename_in [GROUP_WIDTH];
    logic         rename_ready;
    renamed_uop_t renamed_out [GROUP_WIDTH];
    commit_cnt_t  commit_req;
    logic         flush;
    logic         walk_busy;

    // Reference model state
    int           model_map [NUM_ARCH_REGS];
    int           fl_q [$];
    rob_entry_t   rob_q [$];
    int           walk_left;

    logic [31:0]  lcg_state = 32'h85ba0356;
    int           errors;
    int           checks;
    int           test_err_start;
    int           test_chk_start;
    int           cycle_count;
    logic         fired;
    logic         pending;
    logic         seen_busy;
    logic         seen_ready;

    rename_top #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_rename_top (
        .clock        (clock),
        .reset_n      (reset_n),
        .rename_in    (rename_in),
        .rename_ready (rename_ready),
        .renamed_out  (renamed_out),
        .commit_req   (commit_req),
        .flush        (flush),
        .walk_busy    (walk_busy)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // Hard stop if a test never finishes
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= LIMIT) begin
            $display("Timeout: run passed %0d cycles without finishing", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits, the low ones cycle too fast
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;
    endfunction

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("[FAIL] %s: %s expected %0d actual %0d", name, what, expected, actual);
        end
    endtask

    task automatic start_test();
        test_err_start = errors;
        test_chk_start = checks;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name,
                 checks - test_chk_start, errors - test_err_start);
    endtask

    // Random group, narrow span gives repeated registers
    task automatic make_request(input int span);
        for (int i = 0; i < GROUP_WIDTH; i++) begin
            rename_in[i].valid      = (rand_below(4) != 0);
            rename_in[i].dest_valid = (rand_below(4) != 0);
            rename_in[i].dest       = arch_reg_t'(rand_below(span));
            rename_in[i].src1       = arch_reg_t'(rand_below(span));
            rename_in[i].src2       = arch_reg_t'(rand_below(span));
        end
        // Force in-group dependencies now and then
        if (rand_below(2) == 0) begin
            rename_in[1].src1 = rename_in[0].dest;
        end
        if (rand_below(4) == 0) begin
            rename_in[1].dest = rename_in[0].dest;
        end
    endtask

    // ----------------------------------------
    // One cycle, entered and left at negedge
    // ----------------------------------------
    task automatic run_cycle(input string name);
        logic       need [GROUP_WIDTH];
        int         pd [GROUP_WIDTH];
        int         op_s [GROUP_WIDTH];
        int         need_total;
        int         k;
        int         ps1;
        int         ps2;
        int         c_req;
        int         n_commit;
        logic       f_req;
        logic       busy_pre;
        logic       exp_ready;
        logic       exp_fire;
        rob_entry_t e;
        // Let combinational outputs settle
        #2;
        need_total = 0;
        for (int i = 0; i < GROUP_WIDTH; i++) begin
            need[i] = rename_in[i].valid && rename_in[i].dest_valid;
            pd[i]   = 0;
            op_s[i] = 0;
            if (need[i]) begin
                need_total++;
            end
        end
        exp_ready = (walk_left == 0) && !flush
                 && (ROB_DEPTH - rob_q.size() >= GROUP_WIDTH)
                 && (fl_q.size() >= need_total);
        exp_fire  = exp_ready && (rename_in[0].valid || rename_in[1].valid);
        check_value(name, "rename_ready", exp_ready, rename_ready);
        check_value(name, "walk_busy", walk_left > 0, walk_busy);
        seen_busy  = walk_busy;
        seen_ready = rename_ready;
        k = 0;
        for (int i = 0; i < GROUP_WIDTH; i++) begin
            check_value(name, "valid", rename_in[i].valid && exp_ready, renamed_out[i].valid);
            if (exp_fire && rename_in[i].valid) begin
                ps1     = model_map[rename_in[i].src1];
                ps2     = model_map[rename_in[i].src2];
                op_s[i] = model_map[rename_in[i].dest];
                // Older writers in the group override the map, youngest last
                for (int j = 0; j < i; j++) begin
                    if (need[j]) begin
                        if (rename_in[j].dest == rename_in[i].src1) ps1 = pd[j];
                        if (rename_in[j].dest == rename_in[i].src2) ps2 = pd[j];
                        if (rename_in[j].dest == rename_in[i].dest) op_s[i] = pd[j];
                    end
                end
                check_value(name, "psrc1", ps1, renamed_out[i].psrc1);
                check_value(name, "psrc2", ps2, renamed_out[i].psrc2);
                check_value(name, "dest_valid", rename_in[i].dest_valid,
                            renamed_out[i].dest_valid);
                if (rename_in[i].dest_valid) begin
                    pd[i] = fl_q[k];
                    k++;
                    check_value(name, "pdest", pd[i], renamed_out[i].pdest);
                    check_value(name, "old_pdest", op_s[i], renamed_out[i].old_pdest);
                end
            end
        end
        fired    = exp_fire;
        c_req    = int'(commit_req);
        f_req    = flush;
        busy_pre = (walk_left > 0);
        @(posedge clock);
        // Commit, held off while walking
        if (busy_pre) begin
            walk_left--;
        end else begin
            n_commit = (c_req > rob_q.size()) ? rob_q.size() : c_req;
            for (int n = 0; n < n_commit; n++) begin
                e = rob_q.pop_front();
                if (e.dest_valid) begin
                    fl_q.push_back(int'(e.old_pdest));
                end
            end
        end
        // Rename, slots in age order
        if (exp_fire) begin
            for (int i = 0; i < GROUP_WIDTH; i++) begin
                if (rename_in[i].valid) begin
                    if (rename_in[i].dest_valid) begin
                        void'(fl_q.pop_front());
                        model_map[rename_in[i].dest] = pd[i];
                    end
                    e.dest_valid = rename_in[i].dest_valid;
                    e.dest       = rename_in[i].dest;
                    e.pdest      = preg_t'(pd[i]);
                    e.old_pdest  = preg_t'(op_s[i]);
                    rob_q.push_back(e);
                end
            end
        end
        // Flush undoes everything left, newest first
        if (f_req && !busy_pre) begin
            walk_left = (rob_q.size() + 1) / 2;
            while (rob_q.size() > 0) begin
                e = rob_q.pop_back();
                if (e.dest_valid) begin
                    model_map[e.dest] = int'(e.old_pdest);
                    fl_q.push_front(int'(e.pdest));
                end
            end
        end
        @(negedge clock);
    endtask

    // Held request until taken, random commit and flush
    task automatic random_cycles(input string name, input int n, input int span,
                                 input int commit_max, input int flush_pct);
        for (int c = 0; c < n; c++) begin
            if (!pending) begin
                make_request(span);
            end
            commit_req = (commit_max > 0) ? commit_cnt_t'(rand_below(commit_max + 1)) : '0;
            flush      = (walk_left == 0) && (flush_pct > 0) && (rand_below(100) < flush_pct);
            run_cycle(name);
            pending = (rename_in[0].valid || rename_in[1].valid) && !fired;
        end
        commit_req = '0;
        flush      = 1'b0;
    endtask

    // Fill, flush, then count the walk cycles
    task automatic flush_walk(input string name, input int fill);
        int c;
        int remain;
        int exp_walk;
        int busy;
        random_cycles(name, fill, 8, 0, 0);
        c          = rand_below(3);
        remain     = rob_q.size() - ((c > rob_q.size()) ? rob_q.size() : c);
        exp_walk   = (remain + 1) / 2;
        commit_req = commit_cnt_t'(c);
        flush      = 1'b1;
        run_cycle(name);
        commit_req = '0;
        flush      = 1'b0;
        busy       = 0;
        for (int i = 0; i < exp_walk + 2; i++) begin
            run_cycle(name);
            if (seen_busy) begin
                busy++;
            end
        end
        check_value(name, "walk cycles", exp_walk, busy);
        pending = (rename_in[0].valid || rename_in[1].valid) && !fired;
        // Renames after recovery see the committed map
        random_cycles(name, 10, 8, 2, 0);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int stalls;
        reset_n     = 1'b0;
        commit_req  = '0;
        flush       = 1'b0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        walk_left   = 0;
        fired       = 1'b0;
        pending     = 1'b0;
        for (int i = 0; i < GROUP_WIDTH; i++) begin
            rename_in[i] = '0;
        end
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            model_map[i] = i;
        end
        for (int i = 0; i < FREE_DEPTH; i++) begin
            fl_q.push_back(NUM_ARCH_REGS + i);
        end
        repeat (T_RESET) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        // Reset allocation, fixed values from the reset state
        start_test();
        rename_in[0] = '{valid: 1'b1, dest_valid: 1'b1, dest: 5'd1, src1: 5'd2, src2: 5'd3};
        rename_in[1] = '{valid: 1'b1, dest_valid: 1'b1, dest: 5'd4, src1: 5'd1, src2: 5'd1};
        #1;
        check_value("reset_alloc", "pdest0", 32, renamed_out[0].pdest);
        check_value("reset_alloc", "pdest1", 33, renamed_out[1].pdest);
        check_value("reset_alloc", "old_pdest0", 1, renamed_out[0].old_pdest);
        check_value("reset_alloc", "old_pdest1", 4, renamed_out[1].old_pdest);
        check_value("reset_alloc", "psrc1 slot0", 2, renamed_out[0].psrc1);
        check_value("reset_alloc", "psrc1 slot1", 32, renamed_out[1].psrc1);
        run_cycle("reset_alloc");
        // Both slots write r5, slot 1 sees slot 0 as its old mapping
        rename_in[0] = '{valid: 1'b1, dest_valid: 1'b1, dest: 5'd5, src1: 5'd4, src2: 5'd1};
        rename_in[1] = '{valid: 1'b1, dest_valid: 1'b1, dest: 5'd5, src1: 5'd5, src2: 5'd0};
        #1;
        check_value("reset_alloc", "pdest0", 34, renamed_out[0].pdest);
        check_value("reset_alloc", "pdest1", 35, renamed_out[1].pdest);
        check_value("reset_alloc", "old_pdest0", 5, renamed_out[0].old_pdest);
        check_value("reset_alloc", "old_pdest1", 34, renamed_out[1].old_pdest);
        check_value("reset_alloc", "psrc1 slot0", 33, renamed_out[0].psrc1);
        check_value("reset_alloc", "psrc2 slot0", 32, renamed_out[0].psrc2);
        check_value("reset_alloc", "psrc1 slot1", 34, renamed_out[1].psrc1);
        run_cycle("reset_alloc");
        end_test("reset_alloc");

        // Narrow register span for many in-group hits
        start_test();
        random_cycles("bypass", T2, 4, 2, 0);
        end_test("bypass");

        // No commits, ROB fills and stalls
        start_test();
        stalls = 0;
        for (int i = 0; i < T3; i++) begin
            random_cycles("back_pressure", 1, 32, 0, 0);
            if (!seen_ready) begin
                stalls++;
            end
        end
        check_value("back_pressure", "stall seen", 1, stalls > 0);
        end_test("back_pressure");

        // Released pregs come back around the queue
        start_test();
        random_cycles("commit_recycle", T4, 16, 2, 0);
        end_test("commit_recycle");

        start_test();
        for (int r = 0; r < 3; r++) begin
            flush_walk("flush_walk", 6);
        end
        end_test("flush_walk");

        start_test();
        random_cycles("mixed", T6, 12, 2, 3);
        end_test("mixed");

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
rename_types_pkg.sv
rename_ctrl_pkg.sv
freelist.sv
rename_map_table.sv
rename_lane.sv
rename_rob.sv
rename_top.sv
rename_props.sv
rename_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f build.f

status=0
./obj_dir/Vrename_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "Finished with no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
